/* logic/frame_spi_config.svh */
// ====================
// register map and constants of the SPI register path
// addresses and the chip id are one byte each
// the version string is plain ASCII, first character sent first
// scratch depth must be a power of two of at least 2
// ====================
`ifndef FRAME_SPI_CONFIG_SVH
`define FRAME_SPI_CONFIG_SVH

// identity block
`define FRAME_SPI_CHIP_ID 8'h81
`define FRAME_SPI_ADDR_CHIP_ID 8'hDB
`define FRAME_SPI_ADDR_VERSION 8'hB5

// scratch bank, one address per direction
`define FRAME_SPI_ADDR_SCRATCH_WR 8'h20
`define FRAME_SPI_ADDR_SCRATCH_RD 8'h21
`define FRAME_SPI_SCRATCH_DEPTH 4

// length must match the number of characters in the string
`define FRAME_SPI_VERSION_STRING "v24.001.0900"
`define FRAME_SPI_VERSION_LENGTH 12

`endif

/* logic/frame_spi_pkg.sv */
// ====================
// shared types of the SPI register path
// every block moves plain bytes
// the target enumeration is only meaningful inside the selector
// ====================
package frame_spi_pkg;

    // one byte on the SPI wire, MSB first
    typedef logic [7:0] spi_byte_t;

    // register block chosen by the address byte
    typedef enum logic [1:0] {
        target_none    = 2'd0,
        target_chip_id = 2'd1,
        target_version = 2'd2,
        target_scratch = 2'd3
    } subperipheral_t;

endpackage

/* logic/spi_peripheral.sv */
// ====================
// SPI mode 0 peripheral with active low select and MSB first
// pins are sampled on system_clock, so each SPI half period
// must last at least 4 system_clock cycles
// first byte after select falls is the address, later ones are data
// the byte answered on cipo goes out during the next SPI byte
// ====================
`timescale 1ns/1ps

module spi_peripheral (
    input  logic                     system_clock,
    input  logic                     rst_n,
    input  logic                     spi_select,
    input  logic                     spi_clock,
    input  logic                     spi_data_in,
    input  frame_spi_pkg::spi_byte_t cipo,
    input  logic                     cipo_valid,
    output logic                     spi_data_out,
    output frame_spi_pkg::spi_byte_t address,
    output logic                     address_valid,
    output frame_spi_pkg::spi_byte_t copi,
    output logic                     copi_valid,
    output logic                     request,
    output logic                     transaction_active
);

    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic       clock_prev;
    logic       clock_rise;
    logic       clock_fall;

    logic [2:0] bit_count;
    logic       address_done;
    logic [6:0] rx_shift;
    frame_spi_pkg::spi_byte_t rx_byte;
    frame_spi_pkg::spi_byte_t tx_shift;

    // two flop synchronizers where select idles high
    always_ff @(posedge system_clock) begin
        if (!rst_n) begin
            select_sync <= 2'b11;
            clock_sync  <= 2'b00;
            data_sync   <= 2'b00;
            clock_prev  <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync  <= {clock_sync[0], spi_clock};
            data_sync   <= {data_sync[0], spi_data_in};
            clock_prev  <= clock_sync[1];
        end
    end

    assign transaction_active = ~select_sync[1];

    // edges only count while selected
    assign clock_rise = transaction_active & clock_sync[1] & ~clock_prev;
    assign clock_fall = transaction_active & ~clock_sync[1] & clock_prev;

    // bit counter and byte framing
    always_ff @(posedge system_clock) begin
        if (!rst_n) begin
            bit_count     <= 3'd0;
            address_done  <= 1'b0;
            address_valid <= 1'b0;
            copi_valid    <= 1'b0;
        end else begin
            address_valid <= 1'b0;
            copi_valid    <= 1'b0;
            if (!transaction_active) begin
                bit_count    <= 3'd0;
                address_done <= 1'b0;
            end else if (clock_rise) begin
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    // first full byte is the address
                    address_done  <= 1'b1;
                    address_valid <= ~address_done;
                    copi_valid    <= address_done;
                end
            end
        end
    end

    // receive shifter, sampled on rising SPI edges
    always_ff @(posedge system_clock) begin
        if (clock_rise) begin
            rx_shift <= {rx_shift[5:0], data_sync[1]};
            if (bit_count == 3'd7) begin
                rx_byte <= {rx_shift, data_sync[1]};
            end
        end
    end

    // address and data share the capture register and the strobes tell them apart
    assign address = rx_byte;
    assign copi    = rx_byte;

    assign request = address_valid | copi_valid;

    // response shifter
    // MSB sits on the pin after loading, later bits move on falling edges
    // the falling edge that closes a byte leaves the freshly loaded byte alone
    always_ff @(posedge system_clock) begin
        if (!rst_n) begin
            tx_shift <= '0;
        end else if (!transaction_active) begin
            tx_shift <= '0;
        end else if (cipo_valid) begin
            tx_shift <= cipo;
        end else if (clock_fall && bit_count != 3'd0) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign spi_data_out = tx_shift[7];

    // every request is answered in the next cycle
    assert property (@(posedge system_clock) disable iff (!rst_n)
        request |=> cipo_valid);

endmodule

/* logic/spi_subperipheral_selector.sv */
// ====================
// routes the byte stream to one register block per transaction
// target is taken from the address byte and held until select rises
// purely combinational routing with no added latency
// unknown addresses are answered with 0x00 one cycle after request
// ====================
`timescale 1ns/1ps
`include "frame_spi_config.svh"

module spi_subperipheral_selector (
    input  logic                     system_clock,
    input  logic                     rst_n,
    input  logic                     transaction_active,
    input  frame_spi_pkg::spi_byte_t address,
    input  logic                     address_valid,
    input  logic                     request,
    input  frame_spi_pkg::spi_byte_t copi,
    input  logic                     copi_valid,
    output logic                     identity_enable,
    output logic                     identity_version_select,
    output logic                     scratch_enable,
    output logic                     scratch_write_select,
    output logic                     identity_request,
    output logic                     scratch_request,
    output frame_spi_pkg::spi_byte_t scratch_copi,
    output logic                     scratch_copi_valid,
    input  frame_spi_pkg::spi_byte_t identity_cipo,
    input  logic                     identity_cipo_valid,
    input  frame_spi_pkg::spi_byte_t scratch_cipo,
    input  logic                     scratch_cipo_valid,
    output frame_spi_pkg::spi_byte_t cipo,
    output logic                     cipo_valid
);

    frame_spi_pkg::subperipheral_t decoded;
    frame_spi_pkg::subperipheral_t target_now;
    frame_spi_pkg::subperipheral_t target_q;
    logic write_now;
    logic write_q;
    logic none_valid;

    always_comb begin
        case (address)
            `FRAME_SPI_ADDR_CHIP_ID:    decoded = frame_spi_pkg::target_chip_id;
            `FRAME_SPI_ADDR_VERSION:    decoded = frame_spi_pkg::target_version;
            `FRAME_SPI_ADDR_SCRATCH_WR: decoded = frame_spi_pkg::target_scratch;
            `FRAME_SPI_ADDR_SCRATCH_RD: decoded = frame_spi_pkg::target_scratch;
            default:                    decoded = frame_spi_pkg::target_none;
        endcase
    end

    // decoded target is live in the address cycle itself
    assign target_now = !transaction_active ? frame_spi_pkg::target_none :
                        address_valid ? decoded : target_q;
    assign write_now  = address_valid ? (address == `FRAME_SPI_ADDR_SCRATCH_WR) : write_q;

    always_ff @(posedge system_clock) begin
        if (!rst_n) begin
            target_q   <= frame_spi_pkg::target_none;
            write_q    <= 1'b0;
            none_valid <= 1'b0;
        end else begin
            target_q   <= target_now;
            write_q    <= write_now & transaction_active;
            none_valid <= request && (target_now == frame_spi_pkg::target_none);
        end
    end

    assign identity_enable = (target_now == frame_spi_pkg::target_chip_id) ||
                             (target_now == frame_spi_pkg::target_version);
    assign identity_version_select = (target_now == frame_spi_pkg::target_version);
    assign scratch_enable = (target_now == frame_spi_pkg::target_scratch);
    assign scratch_write_select = scratch_enable & write_now;

    assign identity_request   = request & identity_enable;
    assign scratch_request    = request & scratch_enable;
    assign scratch_copi       = copi;
    assign scratch_copi_valid = copi_valid & scratch_enable;

    // answers arrive a cycle after request so the held target picks them
    always_comb begin
        case (target_q)
            frame_spi_pkg::target_chip_id,
            frame_spi_pkg::target_version: begin
                cipo       = identity_cipo;
                cipo_valid = identity_cipo_valid;
            end
            frame_spi_pkg::target_scratch: begin
                cipo       = scratch_cipo;
                cipo_valid = scratch_cipo_valid;
            end
            default: begin
                cipo       = '0;
                cipo_valid = none_valid;
            end
        endcase
    end

    // only the chosen block answers a request
    assert property (@(posedge system_clock) disable iff (!rst_n)
        $onehot0({identity_cipo_valid, scratch_cipo_valid, none_valid}));

endmodule

/* logic/spi_register_identity.sv */
// ====================
// chip id and version string register block
// answers every request one cycle later
// version string restarts at its first character once enable drops
// reads past the end of the string return 0x00
// ====================
`timescale 1ns/1ps
`include "frame_spi_config.svh"

module spi_register_identity (
    input  logic                     system_clock,
    input  logic                     rst_n,
    input  logic                     enable,
    input  logic                     version_select,
    input  logic                     request,
    output frame_spi_pkg::spi_byte_t cipo,
    output logic                     cipo_valid
);

    localparam int version_length = `FRAME_SPI_VERSION_LENGTH;
    localparam logic [8*version_length-1:0] version_text = `FRAME_SPI_VERSION_STRING;
    localparam int index_width = $clog2(version_length + 1);

    logic [index_width-1:0] index;
    frame_spi_pkg::spi_byte_t version_char;

    // string literal keeps its first character in the top byte
    always_comb begin
        version_char = '0;
        for (int i = 0; i < version_length; i++) begin
            if (index == index_width'(i)) begin
                version_char = version_text[8*(version_length-1-i) +: 8];
            end
        end
    end

    always_ff @(posedge system_clock) begin
        if (!rst_n) begin
            index      <= '0;
            cipo_valid <= 1'b0;
        end else begin
            cipo_valid <= request & enable;
            if (!enable) begin
                index <= '0;
            end else if (request && version_select &&
                         index != index_width'(version_length)) begin
                // index stops at the end where the answer is 0x00
                index <= index + index_width'(1);
            end
        end
    end

    always_ff @(posedge system_clock) begin
        if (request) begin
            cipo <= version_select ? version_char : `FRAME_SPI_CHIP_ID;
        end
    end

    // requests only come while enabled, so each one gets an answer
    assert property (@(posedge system_clock) disable iff (!rst_n)
        request |=> cipo_valid);

endmodule

/* logic/spi_register_scratch.sv */
// ====================
// small read/write scratch bank
// index starts at 0 in each transaction and wraps at the depth
// a write answers with the old content of the slot it overwrites
// contents clear only at reset
// ====================
`timescale 1ns/1ps
`include "frame_spi_config.svh"

module spi_register_scratch (
    input  logic                     system_clock,
    input  logic                     rst_n,
    input  logic                     enable,
    input  logic                     write_select,
    input  logic                     request,
    input  frame_spi_pkg::spi_byte_t copi,
    input  logic                     copi_valid,
    output frame_spi_pkg::spi_byte_t cipo,
    output logic                     cipo_valid
);

    localparam int depth = `FRAME_SPI_SCRATCH_DEPTH;
    localparam int index_width = $clog2(depth);

    frame_spi_pkg::spi_byte_t bank [depth];
    logic [index_width-1:0] index;
    logic [index_width-1:0] index_next;

    assign index_next = (index == index_width'(depth - 1)) ? '0 : index + index_width'(1);

    always_ff @(posedge system_clock) begin
        if (!rst_n) begin
            index      <= '0;
            cipo_valid <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                bank[i] <= '0;
            end
        end else begin
            cipo_valid <= request & enable;
            if (!enable) begin
                index <= '0;
            end else if (write_select) begin
                if (copi_valid) begin
                    bank[index] <= copi;
                    index       <= index_next;
                end
            end else if (request) begin
                index <= index_next;
            end
        end
    end

    // in write mode the answer is for the next host byte, so look one slot ahead
    always_ff @(posedge system_clock) begin
        if (request) begin
            cipo <= (write_select && copi_valid) ? bank[index_next] : bank[index];
        end
    end

endmodule

/* logic/frame_spi_top.sv */
// ====================
// SPI register path top level
// system_clock comes from outside
// SPI half period must be at least 4 system_clock cycles
// ====================
`timescale 1ns/1ps

module frame_spi_top (
    input  logic system_clock,
    input  logic rst_n,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data_in,
    output logic spi_data_out
);

    frame_spi_pkg::spi_byte_t address;
    logic address_valid;
    frame_spi_pkg::spi_byte_t copi;
    logic copi_valid;
    frame_spi_pkg::spi_byte_t cipo;
    logic cipo_valid;
    logic request;
    logic transaction_active;

    logic identity_enable;
    logic identity_version_select;
    logic identity_request;
    frame_spi_pkg::spi_byte_t identity_cipo;
    logic identity_cipo_valid;

    logic scratch_enable;
    logic scratch_write_select;
    logic scratch_request;
    frame_spi_pkg::spi_byte_t scratch_copi;
    logic scratch_copi_valid;
    frame_spi_pkg::spi_byte_t scratch_cipo;
    logic scratch_cipo_valid;

    spi_peripheral spi_peripheral_i (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .cipo(cipo),
        .cipo_valid(cipo_valid),
        .spi_data_out(spi_data_out),
        .address(address),
        .address_valid(address_valid),
        .copi(copi),
        .copi_valid(copi_valid),
        .request(request),
        .transaction_active(transaction_active)
    );

    spi_subperipheral_selector spi_subperipheral_selector_i (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .transaction_active(transaction_active),
        .address(address),
        .address_valid(address_valid),
        .request(request),
        .copi(copi),
        .copi_valid(copi_valid),
        .identity_enable(identity_enable),
        .identity_version_select(identity_version_select),
        .scratch_enable(scratch_enable),
        .scratch_write_select(scratch_write_select),
        .identity_request(identity_request),
        .scratch_request(scratch_request),
        .scratch_copi(scratch_copi),
        .scratch_copi_valid(scratch_copi_valid),
        .identity_cipo(identity_cipo),
        .identity_cipo_valid(identity_cipo_valid),
        .scratch_cipo(scratch_cipo),
        .scratch_cipo_valid(scratch_cipo_valid),
        .cipo(cipo),
        .cipo_valid(cipo_valid)
    );

    spi_register_identity spi_register_identity_i (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .enable(identity_enable),
        .version_select(identity_version_select),
        .request(identity_request),
        .cipo(identity_cipo),
        .cipo_valid(identity_cipo_valid)
    );

    spi_register_scratch spi_register_scratch_i (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .enable(scratch_enable),
        .write_select(scratch_write_select),
        .request(scratch_request),
        .copi(scratch_copi),
        .copi_valid(scratch_copi_valid),
        .cipo(scratch_cipo),
        .cipo_valid(scratch_cipo_valid)
    );

endmodule

/* test/tb_clock_gen.sv */
// ====================
// clock and reset source of the testbench
// 20 ns period, reset held low for 10 cycles
// reset is released on a falling edge
// ====================
`timescale 1ns/1ps

module tb_clock_gen (
    output logic system_clock,
    output logic rst_n
);

    localparam int half_period_ns = 10;
    localparam int reset_cycles = 10;

    initial begin
        system_clock = 1'b0;
        forever begin
            #(half_period_ns) system_clock = ~system_clock;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge system_clock);
        @(negedge system_clock);
        rst_n = 1'b1;
    end

endmodule

/* test/tb_frame_spi.sv */
// ====================
// testbench for the SPI register path
// host runs SPI mode 0 with a half period of 4 system_clock cycles
// pins change on the falling system_clock edge
// expected bytes come from a scratch model and the register map macros
// ====================
`timescale 1ns/1ps
`include "frame_spi_config.svh"

module tb_frame_spi;

    localparam int half_period = 4;
    localparam int depth = `FRAME_SPI_SCRATCH_DEPTH;
    localparam int version_length = `FRAME_SPI_VERSION_LENGTH;
    localparam int max_bytes = 16;
    localparam int transaction_count = 25;
    localparam int timeout_cycles = transaction_count * max_bytes * 80 + 1000;

    logic system_clock;
    logic rst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_data_in;
    logic spi_data_out;

    integer seed;
    int error_count;
    logic [7:0] model_bank [depth];
    // index 0 holds the address byte and the data bytes follow
    logic [7:0] tx_bytes [max_bytes];
    logic [7:0] rx_bytes [max_bytes];

    tb_clock_gen tb_clock_gen_i (
        .system_clock(system_clock),
        .rst_n(rst_n)
    );

    frame_spi_top frame_spi_top_i (
        .system_clock(system_clock),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out)
    );

    function automatic logic [7:0] random_byte();
        return 8'($random(seed));
    endfunction

    function automatic int random_range(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    // characters go out in reading order
    function automatic logic [7:0] expected_version_char(input int i);
        string text;
        text = `FRAME_SPI_VERSION_STRING;
        if (i < text.len()) begin
            return text[i];
        end
        return 8'h00;
    endfunction

    function automatic logic [7:0] unknown_address();
        logic [7:0] a;
        a = random_byte();
        while (a == `FRAME_SPI_ADDR_CHIP_ID || a == `FRAME_SPI_ADDR_VERSION ||
               a == `FRAME_SPI_ADDR_SCRATCH_WR || a == `FRAME_SPI_ADDR_SCRATCH_RD) begin
            a = random_byte();
        end
        return a;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge system_clock);
    endtask

    task automatic fill_random(input int count);
        for (int k = 1; k <= count; k++) begin
            tx_bytes[k] = random_byte();
        end
    endtask

    task automatic compare_byte(input string test_name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected 0x%02h, actual 0x%02h", test_name, expected, actual);
        end
    endtask

    // full duplex byte sampled in the middle of each high phase
    task automatic exchange_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_data_in = tx[i];
            wait_cycles(half_period);
            spi_clock = 1'b1;
            wait_cycles(half_period / 2);
            rx[i] = spi_data_out;
            wait_cycles(half_period - half_period / 2);
            spi_clock = 1'b0;
        end
    endtask

    task automatic run_transaction(input logic [7:0] address, input int count);
        logic [7:0] rx;
        @(negedge system_clock);
        spi_select = 1'b0;
        exchange_byte(address, rx);
        rx_bytes[0] = rx;
        for (int k = 1; k <= count; k++) begin
            exchange_byte(tx_bytes[k], rx);
            rx_bytes[k] = rx;
        end
        wait_cycles(half_period);
        spi_select = 1'b1;
        // lets select pass the synchronizer before the next transaction
        wait_cycles(4 * half_period);
    endtask

    // read wraps around the bank past the depth
    task automatic check_scratch_read(input string test_name, input int count);
        fill_random(count);
        run_transaction(`FRAME_SPI_ADDR_SCRATCH_RD, count);
        compare_byte({test_name, " address"}, 8'h00, rx_bytes[0]);
        for (int k = 1; k <= count; k++) begin
            compare_byte($sformatf("%s byte %0d", test_name, k),
                         model_bank[(k-1) % depth], rx_bytes[k]);
        end
    endtask

    task automatic reset_state_read();
        @(negedge system_clock);
        if (spi_data_out !== 1'b0) begin
            error_count++;
            $display("Error reset pin: expected 0x0, actual 0x%0h", spi_data_out);
        end
        fill_random(depth);
        run_transaction(`FRAME_SPI_ADDR_SCRATCH_RD, depth);
        for (int k = 0; k <= depth; k++) begin
            compare_byte($sformatf("reset read byte %0d", k), 8'h00, rx_bytes[k]);
        end
    endtask

    task automatic chip_id_transactions();
        int count;
        for (int t = 0; t < 4; t++) begin
            count = random_range(1, 3);
            fill_random(count);
            run_transaction(`FRAME_SPI_ADDR_CHIP_ID, count);
            compare_byte("chip_id address", 8'h00, rx_bytes[0]);
            for (int k = 1; k <= count; k++) begin
                compare_byte($sformatf("chip_id byte %0d", k), `FRAME_SPI_CHIP_ID, rx_bytes[k]);
            end
        end
    endtask

    task automatic check_version(input string test_name, input int count);
        compare_byte({test_name, " address"}, 8'h00, rx_bytes[0]);
        for (int k = 1; k <= count; k++) begin
            compare_byte($sformatf("%s char %0d", test_name, k - 1),
                         expected_version_char(k - 1), rx_bytes[k]);
        end
    endtask

    task automatic version_transactions();
        int count;
        // two bytes past the end of the string
        count = version_length + 2;
        fill_random(count);
        run_transaction(`FRAME_SPI_ADDR_VERSION, count);
        check_version("version full", count);
        count = random_range(1, version_length);
        fill_random(count);
        run_transaction(`FRAME_SPI_ADDR_VERSION, count);
        check_version("version restart", count);
    endtask

    // each answer is the slot's content just before this byte overwrites it
    task automatic scratch_write(input string test_name);
        int count;
        int index;
        count = random_range(1, 6);
        fill_random(count);
        run_transaction(`FRAME_SPI_ADDR_SCRATCH_WR, count);
        compare_byte({test_name, " address"}, 8'h00, rx_bytes[0]);
        index = 0;
        for (int k = 1; k <= count; k++) begin
            compare_byte($sformatf("%s answer %0d", test_name, k), model_bank[index],
                         rx_bytes[k]);
            model_bank[index] = tx_bytes[k];
            index = (index + 1) % depth;
        end
    endtask

    task automatic unknown_address_transactions();
        logic [7:0] address;
        int count;
        for (int t = 0; t < 3; t++) begin
            address = unknown_address();
            count = random_range(1, 4);
            fill_random(count);
            run_transaction(address, count);
            for (int k = 0; k <= count; k++) begin
                compare_byte($sformatf("unknown 0x%02h byte %0d", address, k), 8'h00,
                             rx_bytes[k]);
            end
            check_scratch_read("unknown readback", depth);
        end
    endtask

    initial begin
        seed = 32'h155f;
        error_count = 0;
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_data_in = 1'b0;
        for (int i = 0; i < depth; i++) begin
            model_bank[i] = 8'h00;
        end
        wait (rst_n === 1'b1);
        reset_state_read();
        chip_id_transactions();
        version_transactions();
        for (int r = 0; r < 6; r++) begin
            scratch_write("scratch_write");
            check_scratch_read("scratch_read", depth + 2);
        end
        unknown_address_transactions();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized for the longest transaction
    initial begin
        repeat (timeout_cycles) @(posedge system_clock);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("errors: %0d", error_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* frame_spi.f */
+incdir+logic
logic/frame_spi_pkg.sv
logic/spi_peripheral.sv
logic/spi_subperipheral_selector.sv
logic/spi_register_identity.sv
logic/spi_register_scratch.sv
logic/frame_spi_top.sv
test/tb_clock_gen.sv
test/tb_frame_spi.sv

/* Makefile */
# Verilator build and run of the SPI register path testbench
# every variable can be overridden on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_frame_spi
FILE_LIST ?= frame_spi.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the simulator output goes to the log, the log decides the status
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^TEST PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
